//--- flist.f
+incdir+logic
logic/execute_pkg.sv
logic/arith_unit.sv
logic/branch_resolve.sv
logic/multiply_pipe.sv
logic/commit_latch.sv
logic/execute_stage.sv
tests/clock_gen.sv
tests/execute_stage_tb.sv

//--- logic/arith_unit.sv
// Purely combinational; shift amount is the low log2(XLEN) bits of port_b
`default_nettype none
`timescale 1ns/1ps

`include "execute_settings.svh"

module arith_unit import execute_pkg::*; (
  input  word_t   port_a,
  input  word_t   port_b,
  input  word_t   pc,
  input  alu_op_t alu_op,
  input  logic    jump_instr,
  output word_t   result
);

  localparam int SHW = $clog2(`XLEN);

  logic [SHW-1:0] shamt;
  word_t          alu_out;

  assign shamt = port_b[SHW-1:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_out = port_a + port_b;
      ALU_SUB:  alu_out = port_a - port_b;
      ALU_AND:  alu_out = port_a & port_b;
      ALU_OR:   alu_out = port_a | port_b;
      ALU_XOR:  alu_out = port_a ^ port_b;
      ALU_SLL:  alu_out = port_a << shamt;
      ALU_SRL:  alu_out = port_a >> shamt;
      // Sign bit fills from the left
      ALU_SRA:  alu_out = word_t'($signed(port_a) >>> shamt);
      ALU_SLT:  alu_out = word_t'($signed(port_a) < $signed(port_b));
      ALU_SLTU: alu_out = word_t'(port_a < port_b);
      default:  alu_out = '0;
    endcase
  end

  // Link value replaces the ALU result for jal/jalr
  assign result = jump_instr ? pc + word_t'(`PC_STEP) : alu_out;

endmodule

`default_nettype wire

//--- logic/branch_resolve.sv
// Redirect outputs are combinational and follow the inputs even while stalled
`default_nettype none
`timescale 1ns/1ps

`include "execute_settings.svh"

module branch_resolve import execute_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       stall,
  input  word_t      pc,
  input  word_t      port_a,
  input  word_t      port_b,
  input  word_t      imm,
  input  logic       branch_instr,
  input  branch_op_t branch_op,
  input  logic       prediction,
  input  logic       jump_instr,
  input  logic       jalr,
  output logic       branch_taken,
  output word_t      resolved_addr,
  output word_t      jump_addr,
  output logic       redirect,
  output word_t      redirect_addr,
  output logic       mispredict_ff
);

  word_t branch_addr;
  word_t jalr_sum;
  logic  mispredict;

  always_comb begin
    case (branch_op)
      BR_BEQ:  branch_taken = (port_a == port_b);
      BR_BNE:  branch_taken = (port_a != port_b);
      BR_BLT:  branch_taken = ($signed(port_a) < $signed(port_b));
      BR_BGE:  branch_taken = ($signed(port_a) >= $signed(port_b));
      BR_BLTU: branch_taken = (port_a < port_b);
      BR_BGEU: branch_taken = (port_a >= port_b);
      default: branch_taken = 1'b0;
    endcase
  end

  assign branch_addr = pc + imm;
  assign jalr_sum    = port_a + imm;

  // jalr drops bit 0 of the computed target
  assign jump_addr = jalr ? {jalr_sum[`XLEN-1:1], 1'b0} : branch_addr;

  assign resolved_addr = branch_taken ? branch_addr : pc + word_t'(`PC_STEP);

  assign mispredict    = branch_instr & (prediction ^ branch_taken);
  assign redirect      = jump_instr | mispredict;
  assign redirect_addr = jump_instr ? jump_addr : resolved_addr;

  // Late copy for the hazard side, frozen with the rest of the stage
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mispredict_ff <= 1'b0;
    end else if (!stall) begin
      mispredict_ff <= redirect;
    end
  end

endmodule

`default_nettype wire

//--- logic/commit_latch.sv
// Flush clears every output and overrides stall; stall holds everything
`default_nettype none
`timescale 1ns/1ps

module commit_latch import execute_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      stall,
  input  logic      flush,
  input  logic      arith_ena,
  input  word_t     result,
  input  reg_idx_t  rd,
  input  cb_index_t index,
  input  logic      mul_valid,
  input  word_t     mul_result,
  input  reg_idx_t  mul_rd,
  input  cb_index_t mul_index,
  input  logic      branch_instr,
  input  logic      branch_taken,
  input  logic      prediction,
  input  word_t     resolved_addr,
  input  logic      jump_instr,
  input  word_t     jump_addr,
  input  word_t     pc,
  output logic      done_a,
  output word_t     wdata_au,
  output reg_idx_t  reg_rd_au,
  output cb_index_t index_a,
  output logic      done_mu,
  output word_t     wdata_mu,
  output reg_idx_t  reg_rd_mu,
  output cb_index_t index_mu,
  output logic      br_instr_c,
  output logic      br_taken_c,
  output logic      prediction_c,
  output word_t     br_resolved_addr,
  output logic      jump_instr_c,
  output word_t     jump_addr_c,
  output word_t     pc_c
);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      {done_a, wdata_au, reg_rd_au, index_a} <= '0;
      {done_mu, wdata_mu, reg_rd_mu, index_mu} <= '0;
      {br_instr_c, br_taken_c, prediction_c, br_resolved_addr} <= '0;
      {jump_instr_c, jump_addr_c, pc_c} <= '0;
    end else if (flush) begin
      {done_a, wdata_au, reg_rd_au, index_a} <= '0;
      {done_mu, wdata_mu, reg_rd_mu, index_mu} <= '0;
      {br_instr_c, br_taken_c, prediction_c, br_resolved_addr} <= '0;
      {jump_instr_c, jump_addr_c, pc_c} <= '0;
    end else if (!stall) begin
      // Arithmetic, also carries the jump link value
      done_a    <= arith_ena;
      wdata_au  <= result;
      reg_rd_au <= rd;
      index_a   <= index;
      // Multiply tags come from the pipe, not from decode
      done_mu   <= mul_valid;
      wdata_mu  <= mul_result;
      reg_rd_mu <= mul_rd;
      index_mu  <= mul_index;
      // Predictor update and jump info
      br_instr_c       <= branch_instr;
      br_taken_c       <= branch_taken;
      prediction_c     <= prediction;
      br_resolved_addr <= resolved_addr;
      jump_instr_c     <= jump_instr;
      jump_addr_c      <= jump_addr;
      pc_c             <= pc;
    end
  end

endmodule

`default_nettype wire

//--- logic/execute_pkg.sv
// Types shared by the execute stage; branch_op_t follows the RV32 funct3 encoding
`default_nettype none

`include "execute_settings.svh"

package execute_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  typedef logic [$clog2(`NUM_CB_ENTRY)-1:0] cb_index_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // Same codes as the funct3 field of branch instructions
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_op_t;

  typedef enum logic [1:0] {
    MUL_MUL,
    MUL_MULH,
    MUL_MULHSU,
    MUL_MULHU
  } mul_op_t;

endpackage

`default_nettype wire

//--- logic/execute_settings.svh
// Build-wide sizes; MUL_STAGES must be 2 or more, NUM_CB_ENTRY a power of two
`ifndef EXECUTE_SETTINGS_SVH
`define EXECUTE_SETTINGS_SVH

// Data path width
`define XLEN 32

// Architectural register index width
`define REG_IDX_W 5

// Completion buffer depth
`define NUM_CB_ENTRY 16

// Pipeline registers inside the multiplier
`define MUL_STAGES 3

// Bytes per instruction, used for the fall-through and link values
`define PC_STEP 4

`endif

//--- logic/execute_stage.sv
// One instruction per cycle from decode; stall and flush are plain levels
`default_nettype none
`timescale 1ns/1ps

`include "execute_settings.svh"

module execute_stage import execute_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       stall,
  input  logic       flush,
  input  word_t      pc,
  input  word_t      port_a,
  input  word_t      port_b,
  input  word_t      imm,
  input  reg_idx_t   rd,
  input  cb_index_t  index,
  input  logic       arith_ena,
  input  alu_op_t    alu_op,
  input  logic       branch_instr,
  input  branch_op_t branch_op,
  input  logic       prediction,
  input  logic       jump_instr,
  input  logic       jalr,
  input  logic       mult_ena,
  input  mul_op_t    mul_op,
  output logic       done_a,
  output word_t      wdata_au,
  output reg_idx_t   reg_rd_au,
  output cb_index_t  index_a,
  output logic       done_mu,
  output word_t      wdata_mu,
  output reg_idx_t   reg_rd_mu,
  output cb_index_t  index_mu,
  output logic       br_instr_c,
  output logic       br_taken_c,
  output logic       prediction_c,
  output word_t      br_resolved_addr,
  output logic       jump_instr_c,
  output word_t      jump_addr_c,
  output word_t      pc_c,
  output logic       redirect,
  output word_t      redirect_addr,
  output logic       mispredict_ff,
  output logic       busy_mu
);

  word_t     result;
  logic      branch_taken;
  word_t     resolved_addr;
  word_t     jump_addr;
  logic      mul_valid;
  word_t     mul_result;
  reg_idx_t  mul_rd;
  cb_index_t mul_index;

  arith_unit arith_unit_i (
    .port_a     (port_a),
    .port_b     (port_b),
    .pc         (pc),
    .alu_op     (alu_op),
    .jump_instr (jump_instr),
    .result     (result)
  );

  branch_resolve branch_resolve_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .stall         (stall),
    .pc            (pc),
    .port_a        (port_a),
    .port_b        (port_b),
    .imm           (imm),
    .branch_instr  (branch_instr),
    .branch_op     (branch_op),
    .prediction    (prediction),
    .jump_instr    (jump_instr),
    .jalr          (jalr),
    .branch_taken  (branch_taken),
    .resolved_addr (resolved_addr),
    .jump_addr     (jump_addr),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .mispredict_ff (mispredict_ff)
  );

  multiply_pipe #(
    .STAGES (`MUL_STAGES)
  ) multiply_pipe_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .stall      (stall),
    .flush      (flush),
    .mult_ena   (mult_ena),
    .mul_op     (mul_op),
    .port_a     (port_a),
    .port_b     (port_b),
    .rd         (rd),
    .index      (index),
    .mul_valid  (mul_valid),
    .mul_result (mul_result),
    .mul_rd     (mul_rd),
    .mul_index  (mul_index),
    .busy_mu    (busy_mu)
  );

  commit_latch commit_latch_i (
    .CLK              (CLK),
    .nRST             (nRST),
    .stall            (stall),
    .flush            (flush),
    .arith_ena        (arith_ena),
    .result           (result),
    .rd               (rd),
    .index            (index),
    .mul_valid        (mul_valid),
    .mul_result       (mul_result),
    .mul_rd           (mul_rd),
    .mul_index        (mul_index),
    .branch_instr     (branch_instr),
    .branch_taken     (branch_taken),
    .prediction       (prediction),
    .resolved_addr    (resolved_addr),
    .jump_instr       (jump_instr),
    .jump_addr        (jump_addr),
    .pc               (pc),
    .done_a           (done_a),
    .wdata_au         (wdata_au),
    .reg_rd_au        (reg_rd_au),
    .index_a          (index_a),
    .done_mu          (done_mu),
    .wdata_mu         (wdata_mu),
    .reg_rd_mu        (reg_rd_mu),
    .index_mu         (index_mu),
    .br_instr_c       (br_instr_c),
    .br_taken_c       (br_taken_c),
    .prediction_c     (prediction_c),
    .br_resolved_addr (br_resolved_addr),
    .jump_instr_c     (jump_instr_c),
    .jump_addr_c      (jump_addr_c),
    .pc_c             (pc_c)
  );

endmodule

`default_nettype wire

//--- logic/multiply_pipe.sv
// STAGES must be at least 2; latency is STAGES edges from issue to mul_valid
`default_nettype none
`timescale 1ns/1ps

`include "execute_settings.svh"

module multiply_pipe import execute_pkg::*; #(
  parameter int STAGES = `MUL_STAGES
) (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      stall,
  input  logic      flush,
  input  logic      mult_ena,
  input  mul_op_t   mul_op,
  input  word_t     port_a,
  input  word_t     port_b,
  input  reg_idx_t  rd,
  input  cb_index_t index,
  output logic      mul_valid,
  output word_t     mul_result,
  output reg_idx_t  mul_rd,
  output cb_index_t mul_index,
  output logic      busy_mu
);

  localparam int PW = 2 * `XLEN;

  logic [STAGES-1:0] valid_q;
  mul_op_t           op_q   [STAGES];
  reg_idx_t          rd_q   [STAGES];
  cb_index_t         idx_q  [STAGES];
  word_t             a_q;
  word_t             b_q;
  logic [PW-1:0]     prod_q [1:STAGES-1];

  logic              a_signed;
  logic              b_signed;
  logic signed [`XLEN:0]  a_ext;
  logic signed [`XLEN:0]  b_ext;
  logic signed [PW+1:0]   prod_full;

  // One extra bit per operand covers signed, unsigned and mixed forms
  assign a_signed  = (op_q[0] == MUL_MULH) || (op_q[0] == MUL_MULHSU);
  assign b_signed  = (op_q[0] == MUL_MULH);
  assign a_ext     = {a_signed & a_q[`XLEN-1], a_q};
  assign b_ext     = {b_signed & b_q[`XLEN-1], b_q};
  assign prod_full = a_ext * b_ext;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
      a_q     <= '0;
      b_q     <= '0;
      for (int i = 0; i < STAGES; i++) begin
        op_q[i]  <= MUL_MUL;
        rd_q[i]  <= '0;
        idx_q[i] <= '0;
      end
      for (int i = 1; i < STAGES; i++) begin
        prod_q[i] <= '0;
      end
    end else if (flush) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q  <= {valid_q[STAGES-2:0], mult_ena};
      a_q      <= port_a;
      b_q      <= port_b;
      op_q[0]  <= mul_op;
      rd_q[0]  <= rd;
      idx_q[0] <= index;
      for (int i = 1; i < STAGES; i++) begin
        op_q[i]  <= op_q[i-1];
        rd_q[i]  <= rd_q[i-1];
        idx_q[i] <= idx_q[i-1];
      end
      prod_q[1] <= prod_full[PW-1:0];
      for (int i = 2; i < STAGES; i++) begin
        prod_q[i] <= prod_q[i-1];
      end
    end
  end

  // Low word for mul, high word for the mulh variants
  assign mul_result = (op_q[STAGES-1] == MUL_MUL) ? prod_q[STAGES-1][`XLEN-1:0]
                                                   : prod_q[STAGES-1][PW-1:`XLEN];
  assign mul_valid  = valid_q[STAGES-1];
  assign mul_rd     = rd_q[STAGES-1];
  assign mul_index  = idx_q[STAGES-1];
  assign busy_mu    = |valid_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.
# The exit status is the simulator's own, nonzero when the run fails.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module execute_stage_tb \
  -f flist.f \
  -o execute_stage_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build returned status $build_status"
  exit "$build_status"
fi

./obj_dir/execute_stage_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
  echo "Simulation run returned status $run_status"
  exit "$run_status"
fi

exit 0

//--- tests/clock_gen.sv
// Clock runs from time zero; reset is low from the start and releases on a falling edge
`default_nettype none
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // Release lines up with the testbench's drive edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/execute_stage_tb.sv
// Directed tests; multiply latency assumed to be MUL_STAGES+1 edges with stall low
`default_nettype none
`timescale 1ns/1ps

`include "execute_settings.svh"

module execute_stage_tb import execute_pkg::*; ();

  localparam int    MUL_LAT     = `MUL_STAGES + 1;
  localparam int    NUM_OPS     = 1 + 60 + 40 + 2 + (20 + MUL_LAT) + 20;
  localparam int    WATCHDOG_NS = (NUM_OPS * 8 + 50) * 20;
  localparam word_t SIGN_BIT    = word_t'(1) << (`XLEN - 1);

  logic       CLK;
  logic       nRST;
  logic       stall;
  logic       flush;
  word_t      pc;
  word_t      port_a;
  word_t      port_b;
  word_t      imm;
  reg_idx_t   rd;
  cb_index_t  index;
  logic       arith_ena;
  alu_op_t    alu_op;
  logic       branch_instr;
  branch_op_t branch_op;
  logic       prediction;
  logic       jump_instr;
  logic       jalr;
  logic       mult_ena;
  mul_op_t    mul_op;
  logic       done_a;
  word_t      wdata_au;
  reg_idx_t   reg_rd_au;
  cb_index_t  index_a;
  logic       done_mu;
  word_t      wdata_mu;
  reg_idx_t   reg_rd_mu;
  cb_index_t  index_mu;
  logic       br_instr_c;
  logic       br_taken_c;
  logic       prediction_c;
  word_t      br_resolved_addr;
  logic       jump_instr_c;
  word_t      jump_addr_c;
  word_t      pc_c;
  logic       redirect;
  word_t      redirect_addr;
  logic       mispredict_ff;
  logic       busy_mu;

  integer     seed;
  branch_op_t br_ops [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

  // Multiply scoreboard with the oldest entry at the front
  word_t      q_res [$];
  reg_idx_t   q_rd  [$];
  cb_index_t  q_idx [$];
  int         q_age [$];
  int         mu_count;
  logic       held_valid;

  clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) clock_gen_i (.CLK(CLK), .nRST(nRST));

  execute_stage execute_stage_i (.*);

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("Error: time %0t, %s expected %h, got %h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_reg_idx(input string name, input reg_idx_t expected,
                               input reg_idx_t actual);
    if (actual !== expected) begin
      $display("Error: time %0t, %s expected %h, got %h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_index(input string name, input cb_index_t expected,
                             input cb_index_t actual);
    if (actual !== expected) begin
      $display("Error: time %0t, %s expected %h, got %h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error: time %0t, %s expected %b, got %b", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Even offset in the range of a 13-bit branch immediate
  function automatic word_t rand_offset();
    logic [31:0] r;
    r = rand32();
    return {{(`XLEN - 13){r[12]}}, r[12:1], 1'b0};
  endfunction

  function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
    logic [4:0] sh;
    word_t      fill;
    sh   = b[4:0];
    fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | fill;
      // Differing signs decide on the sign of a alone
      ALU_SLT:  return (a[`XLEN-1] != b[`XLEN-1]) ? word_t'(a[`XLEN-1]) : word_t'(a < b);
      ALU_SLTU: return word_t'(a < b);
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_ref(input branch_op_t op, input word_t a, input word_t b);
    word_t sa;
    word_t sb;
    // Flipping the sign bit turns a signed compare into an unsigned one
    sa = a ^ SIGN_BIT;
    sb = b ^ SIGN_BIT;
    case (op)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return sa < sb;
      BR_BGE:  return !(sa < sb);
      BR_BLTU: return a < b;
      default: return !(a < b);
    endcase
  endfunction

  function automatic word_t mul_ref(input mul_op_t op, input word_t a, input word_t b);
    logic [2*`XLEN-1:0] ax;
    logic [2*`XLEN-1:0] bx;
    logic [2*`XLEN-1:0] p;
    ax = (op == MUL_MULH || op == MUL_MULHSU) ? {{`XLEN{a[`XLEN-1]}}, a} : {{`XLEN{1'b0}}, a};
    bx = (op == MUL_MULH) ? {{`XLEN{b[`XLEN-1]}}, b} : {{`XLEN{1'b0}}, b};
    p  = ax * bx;
    return (op == MUL_MUL) ? p[`XLEN-1:0] : p[2*`XLEN-1:`XLEN];
  endfunction

  task automatic idle_inputs();
    arith_ena    = 1'b0;
    branch_instr = 1'b0;
    jump_instr   = 1'b0;
    jalr         = 1'b0;
    mult_ena     = 1'b0;
    prediction   = 1'b0;
    stall        = 1'b0;
    flush        = 1'b0;
  endtask

  task automatic check_reset();
    check_bit("done_a", 1'b0, done_a);
    check_word("wdata_au", '0, wdata_au);
    check_reg_idx("reg_rd_au", '0, reg_rd_au);
    check_index("index_a", '0, index_a);
    check_bit("done_mu", 1'b0, done_mu);
    check_word("wdata_mu", '0, wdata_mu);
    check_reg_idx("reg_rd_mu", '0, reg_rd_mu);
    check_index("index_mu", '0, index_mu);
    check_bit("br_instr_c", 1'b0, br_instr_c);
    check_bit("br_taken_c", 1'b0, br_taken_c);
    check_bit("prediction_c", 1'b0, prediction_c);
    check_word("br_resolved_addr", '0, br_resolved_addr);
    check_bit("jump_instr_c", 1'b0, jump_instr_c);
    check_word("jump_addr_c", '0, jump_addr_c);
    check_word("pc_c", '0, pc_c);
    check_bit("mispredict_ff", 1'b0, mispredict_ff);
    check_bit("busy_mu", 1'b0, busy_mu);
  endtask

  task automatic run_alu(input int count);
    word_t expected;
    for (int i = 0; i < count; i++) begin
      arith_ena = 1'b1;
      alu_op    = alu_op_t'(4'(rand32() % 10));
      port_a    = rand32();
      port_b    = rand32();
      rd        = reg_idx_t'(rand32());
      index     = cb_index_t'(rand32());
      expected  = alu_ref(alu_op, port_a, port_b);
      @(negedge CLK);
      check_word("wdata_au", expected, wdata_au);
      check_reg_idx("reg_rd_au", rd, reg_rd_au);
      check_index("index_a", index, index_a);
      check_bit("done_a", 1'b1, done_a);
    end
  endtask

  task automatic run_branches(input int count);
    logic  taken;
    word_t target;
    for (int i = 0; i < count; i++) begin
      branch_instr = 1'b1;
      branch_op    = br_ops[3'(rand32() % 6)];
      port_a       = rand32();
      // Equal operands half the time so beq/bge paths are hit
      port_b       = rand32();
      port_b       = port_b[0] ? port_a : rand32();
      pc           = rand32() & 32'hffff_fffc;
      imm          = rand_offset();
      prediction   = 1'(rand32());
      taken        = branch_ref(branch_op, port_a, port_b);
      target       = taken ? pc + imm : pc + word_t'(`PC_STEP);
      #1;
      check_bit("redirect", prediction != taken, redirect);
      check_word("redirect_addr", target, redirect_addr);
      @(negedge CLK);
      check_bit("br_instr_c", 1'b1, br_instr_c);
      check_bit("br_taken_c", taken, br_taken_c);
      check_bit("prediction_c", prediction, prediction_c);
      check_word("br_resolved_addr", target, br_resolved_addr);
      check_word("pc_c", pc, pc_c);
      check_bit("mispredict_ff", prediction != taken, mispredict_ff);
    end
  endtask

  task automatic run_jumps();
    word_t target;
    for (int j = 0; j < 2; j++) begin
      idle_inputs();
      jump_instr = 1'b1;
      jalr       = (j == 1);
      arith_ena  = 1'b1;
      pc         = rand32() & 32'hffff_fffc;
      // Odd base with an even offset makes the jalr sum odd
      port_a     = rand32() | 32'h1;
      imm        = rand_offset();
      rd         = reg_idx_t'(rand32());
      index      = cb_index_t'(rand32());
      target     = jalr ? ((port_a + imm) & 32'hffff_fffe) : pc + imm;
      #1;
      check_bit("redirect", 1'b1, redirect);
      check_word("redirect_addr", target, redirect_addr);
      @(negedge CLK);
      check_word("wdata_au", pc + word_t'(`PC_STEP), wdata_au);
      check_bit("done_a", 1'b1, done_a);
      check_bit("jump_instr_c", 1'b1, jump_instr_c);
      check_word("jump_addr_c", target, jump_addr_c);
      check_bit("mispredict_ff", 1'b1, mispredict_ff);
    end
  endtask

  // One cycle of multiply traffic; a stalled instruction stays on the inputs
  task automatic mul_cycle(input logic issue, input logic hold, input logic clear);
    logic      snap_done;
    word_t     snap_mu;
    reg_idx_t  snap_rd;
    cb_index_t snap_idx;
    word_t     snap_au;
    word_t     snap_pc;
    logic      snap_mis;
    if (issue && !held_valid) begin
      mul_op     = mul_op_t'(2'(rand32()));
      port_a     = rand32();
      port_b     = rand32();
      rd         = reg_idx_t'(rand32());
      index      = cb_index_t'(rand32());
      pc         = rand32() & 32'hffff_fffc;
      // Random jumps and ALU enables keep mispredict_ff and done_a moving
      arith_ena  = 1'(rand32());
      jump_instr = 1'(rand32());
    end
    mult_ena   = issue;
    stall      = hold;
    flush      = clear;
    held_valid = hold && issue && !clear;
    snap_done  = done_mu;
    snap_mu    = wdata_mu;
    snap_rd    = reg_rd_mu;
    snap_idx   = index_mu;
    snap_au    = wdata_au;
    snap_pc    = pc_c;
    snap_mis   = mispredict_ff;
    @(negedge CLK);
    if (clear) begin
      q_res.delete();
      q_rd.delete();
      q_idx.delete();
      q_age.delete();
      check_bit("done_mu", 1'b0, done_mu);
      check_word("wdata_mu", '0, wdata_mu);
      check_bit("done_a", 1'b0, done_a);
      check_word("wdata_au", '0, wdata_au);
      check_word("pc_c", '0, pc_c);
      check_word("br_resolved_addr", '0, br_resolved_addr);
      check_word("jump_addr_c", '0, jump_addr_c);
    end else if (hold) begin
      check_bit("done_mu", snap_done, done_mu);
      check_word("wdata_mu", snap_mu, wdata_mu);
      check_reg_idx("reg_rd_mu", snap_rd, reg_rd_mu);
      check_index("index_mu", snap_idx, index_mu);
      check_word("wdata_au", snap_au, wdata_au);
      check_word("pc_c", snap_pc, pc_c);
      check_bit("mispredict_ff", snap_mis, mispredict_ff);
    end else begin
      foreach (q_age[i]) begin
        q_age[i]++;
      end
      if (issue) begin
        q_res.push_back(mul_ref(mul_op, port_a, port_b));
        q_rd.push_back(rd);
        q_idx.push_back(index);
        q_age.push_back(1);
      end
      if (q_age.size() != 0 && q_age[0] == MUL_LAT) begin
        check_bit("done_mu", 1'b1, done_mu);
        check_word("wdata_mu", q_res.pop_front(), wdata_mu);
        check_reg_idx("reg_rd_mu", q_rd.pop_front(), reg_rd_mu);
        check_index("index_mu", q_idx.pop_front(), index_mu);
        void'(q_age.pop_front());
        mu_count++;
      end else begin
        check_bit("done_mu", 1'b0, done_mu);
      end
    end
    check_bit("busy_mu", q_age.size() != 0, busy_mu);
  endtask

  task automatic run_multiply(input int count);
    mu_count = 0;
    repeat (count) mul_cycle(1'b1, 1'b0, 1'b0);
    repeat (MUL_LAT) mul_cycle(1'b0, 1'b0, 1'b0);
    if (mu_count != count || q_age.size() != 0) begin
      abort_run("Not every issued multiply reached the commit outputs");
    end
  endtask

  task automatic run_stall_flush();
    repeat (3) mul_cycle(1'b1, 1'b0, 1'b0);
    repeat (3) mul_cycle(1'b1, 1'b1, 1'b0);
    mul_cycle(1'b1, 1'b0, 1'b0);
    repeat (MUL_LAT) mul_cycle(1'b0, 1'b0, 1'b0);
    if (q_age.size() != 0) begin
      abort_run("Multiplies were still pending after the stall drained");
    end
    // First result is on the commit outputs with three more in flight
    repeat (4) mul_cycle(1'b1, 1'b0, 1'b0);
    // Flush wins over a simultaneous stall
    mul_cycle(1'b0, 1'b1, 1'b1);
    repeat (MUL_LAT) mul_cycle(1'b0, 1'b0, 1'b0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed       = 32'h7f8a;
    held_valid = 1'b0;
    mu_count   = 0;
    pc         = '0;
    port_a     = '0;
    port_b     = '0;
    imm        = '0;
    rd         = '0;
    index      = '0;
    alu_op     = ALU_ADD;
    branch_op  = BR_BEQ;
    mul_op     = MUL_MUL;
    idle_inputs();
    @(posedge nRST);
    check_reset();
    run_alu(60);
    idle_inputs();
    run_branches(40);
    run_jumps();
    idle_inputs();
    run_multiply(20);
    run_stall_flush();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
